/* src/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// data and address word width
`define DC_WORD_W 32

// sets per way
`define DC_SETS 8

`define DC_IDX_W 3

// address is tag[31:6], index[5:3], block word[2], byte[1:0]
`define DC_TAG_W 26

`endif

/* src/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

        typedef logic [`DC_WORD_W-1:0] word_t;
        typedef logic [`DC_TAG_W-1:0]  tag_t;
        typedef logic [`DC_IDX_W-1:0]  idx_t;

        // controller states
        typedef enum logic [3:0] {
                LOOKUP     = 4'd0,
                WB0        = 4'd1,
                WB1        = 4'd2,
                FILL0      = 4'd3,
                FILL1      = 4'd4,
                FLUSH_SCAN = 4'd5,
                FLUSH_WB0  = 4'd6,
                FLUSH_WB1  = 4'd7,
                FLUSHED    = 4'd8
        } dc_state_e;

endpackage

/* src/dcache_tags.sv */
`include "dcache_macros.svh"

module dcache_tags (
        input  logic             CLK,
        input  logic             nRST,
        input  dcache_pkg::idx_t set_idx,
        input  dcache_pkg::tag_t look_tag,
        input  logic             tag_fill,
        input  logic             tag_fill_way,
        input  logic             tag_fill_dirty,
        input  logic             tag_inval,
        input  logic             tag_inval_way,
        input  logic             lru_touch,
        input  logic             lru_way,
        output logic             hit,
        output logic             hit_way,
        output logic             victim_way,
        output logic             victim_dirty,
        output dcache_pkg::tag_t victim_tag,
        output logic [1:0]       way_dirty
);
        import dcache_pkg::*;

        tag_t                      tag_mem [2][`DC_SETS];
        logic [1:0][`DC_SETS-1:0]  valid;
        logic [1:0][`DC_SETS-1:0]  dirty;
        // per set, the least recently used way
        logic [`DC_SETS-1:0]       lru;
        logic [1:0]                way_valid;
        logic [1:0]                way_hit;

        always_comb begin
                for (int w = 0; w < 2; w++) begin
                        way_valid[w] = valid[w][set_idx];
                        way_dirty[w] = dirty[w][set_idx];
                        way_hit[w]   = way_valid[w] && (tag_mem[w][set_idx] == look_tag);
                end
        end

        assign hit     = |way_hit;
        assign hit_way = way_hit[1];

        // empty way first, way 0 before way 1, then lru
        always_comb begin
                if (!way_valid[0]) begin
                        victim_way = 1'b0;
                end else if (!way_valid[1]) begin
                        victim_way = 1'b1;
                end else begin
                        victim_way = lru[set_idx];
                end
        end

        assign victim_dirty = way_dirty[victim_way];
        assign victim_tag   = tag_mem[victim_way][set_idx];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        valid <= '0;
                        dirty <= '0;
                        lru   <= '0;
                end else begin
                        if (tag_inval) begin
                                valid[tag_inval_way][set_idx] <= 1'b0;
                                dirty[tag_inval_way][set_idx] <= 1'b0;
                        end
                        // a store hit comes in as a fill of the hit way
                        if (tag_fill) begin
                                valid[tag_fill_way][set_idx] <= 1'b1;
                                dirty[tag_fill_way][set_idx] <= tag_fill_dirty;
                        end
                        if (lru_touch) begin
                                lru[set_idx] <= ~lru_way;
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (tag_fill) begin
                        tag_mem[tag_fill_way][set_idx] <= look_tag;
                end
        end

        // a tag lives in at most one way of a set
        a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
                !(way_hit[0] && way_hit[1]));

endmodule

/* src/dcache_data.sv */
`include "dcache_macros.svh"

module dcache_data (
        input  logic              CLK,
        input  dcache_pkg::idx_t  set_idx,
        input  logic              data_way,
        input  logic              data_word,
        input  logic              data_wen,
        input  dcache_pkg::word_t data_wdata,
        output dcache_pkg::word_t data_rdata
);
        import dcache_pkg::*;

        // indexed by way, set, block word
        word_t mem [2][`DC_SETS][2];

        // combinational read of the addressed word
        assign data_rdata = mem[data_way][set_idx][data_word];

        always_ff @(posedge CLK) begin
                if (data_wen) begin
                        mem[data_way][set_idx][data_word] <= data_wdata;
                end
        end

endmodule

/* src/dcache_ctrl.sv */
`include "dcache_macros.svh"

module dcache_ctrl (
        input  logic              CLK,
        input  logic              nRST,
        input  logic              dmemREN,
        input  logic              dmemWEN,
        input  dcache_pkg::word_t dmemaddr,
        input  dcache_pkg::word_t dmemstore,
        input  logic              halt,
        output logic              dhit,
        output dcache_pkg::word_t dmemload,
        output logic              flushed,
        input  dcache_pkg::word_t dload,
        input  logic              dwait,
        output logic              dREN,
        output logic              dWEN,
        output dcache_pkg::word_t daddr,
        output dcache_pkg::word_t dstore,
        output dcache_pkg::idx_t  set_idx,
        output dcache_pkg::tag_t  look_tag,
        output logic              tag_fill,
        output logic              tag_fill_way,
        output logic              tag_fill_dirty,
        output logic              tag_inval,
        output logic              tag_inval_way,
        output logic              lru_touch,
        output logic              lru_way,
        input  logic              hit,
        input  logic              hit_way,
        input  logic              victim_way,
        input  logic              victim_dirty,
        input  dcache_pkg::tag_t  victim_tag,
        input  logic [1:0]        way_dirty,
        output logic              data_way,
        output logic              data_word,
        output logic              data_wen,
        output dcache_pkg::word_t data_wdata,
        input  dcache_pkg::word_t data_rdata
);
        import dcache_pkg::*;

        dc_state_e state;
        dc_state_e next_state;
        idx_t      flush_idx;
        idx_t      next_flush_idx;
        logic      vway;
        logic      next_vway;
        tag_t      vtag;
        tag_t      next_vtag;
        tag_t      req_tag;
        idx_t      req_idx;
        logic      req_word;
        logic      req;
        logic      in_flush;
        logic      in_fill;

        assign req_tag  = dmemaddr[`DC_WORD_W-1 -: `DC_TAG_W];
        assign req_idx  = dmemaddr[3 +: `DC_IDX_W];
        assign req_word = dmemaddr[2];
        assign req      = dmemREN | dmemWEN;

        assign in_flush = (state == FLUSH_SCAN) || (state == FLUSH_WB0) ||
                          (state == FLUSH_WB1) || (state == FLUSHED);
        assign in_fill  = (state == FILL0) || (state == FILL1);

        assign set_idx  = in_flush ? flush_idx : req_idx;
        // inverted so the victim way can never match during a flush
        assign look_tag = in_flush ? ~victim_tag : req_tag;

        // write-backs use the latched victim tag, fills the request tag
        assign daddr    = {(in_fill ? req_tag : vtag), set_idx, data_word, 2'b00};
        assign dstore   = data_rdata;
        assign dmemload = data_rdata;
        assign flushed  = (state == FLUSHED);

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state     <= LOOKUP;
                        flush_idx <= '0;
                        vway      <= 1'b0;
                end else begin
                        state     <= next_state;
                        flush_idx <= next_flush_idx;
                        vway      <= next_vway;
                end
        end

        always_ff @(posedge CLK) begin
                vtag <= next_vtag;
        end

        always_comb begin
                next_state     = state;
                next_flush_idx = flush_idx;
                next_vway      = vway;
                next_vtag      = vtag;
                dhit           = 1'b0;
                dREN           = 1'b0;
                dWEN           = 1'b0;
                tag_fill       = 1'b0;
                tag_fill_way   = vway;
                tag_fill_dirty = 1'b0;
                tag_inval      = 1'b0;
                tag_inval_way  = vway;
                lru_touch      = 1'b0;
                lru_way        = hit_way;
                data_way       = vway;
                data_word      = 1'b0;
                data_wen       = 1'b0;
                data_wdata     = dload;

                unique case (state)
                LOOKUP: begin
                        data_way   = hit_way;
                        data_word  = req_word;
                        data_wdata = dmemstore;
                        if (halt) begin
                                next_flush_idx = '0;
                                next_state     = FLUSH_SCAN;
                        end else if (req && hit) begin
                                dhit      = 1'b1;
                                lru_touch = 1'b1;
                                if (dmemWEN) begin
                                        data_wen       = 1'b1;
                                        tag_fill       = 1'b1;
                                        tag_fill_way   = hit_way;
                                        tag_fill_dirty = 1'b1;
                                end
                        end else if (req) begin
                                next_vway  = victim_way;
                                next_vtag  = victim_tag;
                                next_state = victim_dirty ? WB0 : FILL0;
                        end
                end
                WB0, FLUSH_WB0: begin
                        dWEN = 1'b1;
                        if (!dwait) begin
                                next_state = (state == WB0) ? WB1 : FLUSH_WB1;
                        end
                end
                WB1, FLUSH_WB1: begin
                        data_word = 1'b1;
                        dWEN      = 1'b1;
                        if (!dwait) begin
                                tag_inval  = 1'b1;
                                next_state = (state == WB1) ? FILL0 : FLUSH_SCAN;
                        end
                end
                FILL0, FILL1: begin
                        data_word = (state == FILL1);
                        dREN      = 1'b1;
                        // store miss merges its word as the block arrives
                        if (dmemWEN && (req_word == data_word)) begin
                                data_wdata = dmemstore;
                        end
                        if (!dwait) begin
                                data_wen = 1'b1;
                                if (state == FILL1) begin
                                        tag_fill       = 1'b1;
                                        tag_fill_dirty = dmemWEN;
                                        next_state     = LOOKUP;
                                end else begin
                                        next_state = FILL1;
                                end
                        end
                end
                FLUSH_SCAN: begin
                        if (victim_dirty) begin
                                next_vway  = victim_way;
                                next_vtag  = victim_tag;
                                next_state = FLUSH_WB0;
                        end else if (|way_dirty) begin
                                // claim the clean way, lru then picks the dirty one
                                tag_fill     = 1'b1;
                                tag_fill_way = victim_way;
                                lru_touch    = 1'b1;
                                lru_way      = victim_way;
                        end else if (flush_idx == idx_t'(`DC_SETS - 1)) begin
                                next_state = FLUSHED;
                        end else begin
                                next_flush_idx = flush_idx + 1'b1;
                        end
                end
                FLUSHED: begin
                        // held until reset
                        next_state = FLUSHED;
                end
                endcase
        end

        a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
                !(dREN && dWEN));

        // a hit answers exactly one kind of request
        a_hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
                (state == LOOKUP && dhit) |-> (req && !(dmemREN && dmemWEN)));

endmodule

/* src/dcache.sv */
`include "dcache_macros.svh"

module dcache (
        input  logic              CLK,
        input  logic              nRST,
        input  logic              dmemREN,
        input  logic              dmemWEN,
        input  dcache_pkg::word_t dmemaddr,
        input  dcache_pkg::word_t dmemstore,
        input  logic              halt,
        input  dcache_pkg::word_t dload,
        input  logic              dwait,
        output logic              dhit,
        output dcache_pkg::word_t dmemload,
        output logic              flushed,
        output logic              dREN,
        output logic              dWEN,
        output dcache_pkg::word_t daddr,
        output dcache_pkg::word_t dstore
);

        logic [`DC_IDX_W-1:0]  set_idx;
        logic [`DC_TAG_W-1:0]  look_tag;
        logic [`DC_TAG_W-1:0]  victim_tag;
        logic                  tag_fill;
        logic                  tag_fill_way;
        logic                  tag_fill_dirty;
        logic                  tag_inval;
        logic                  tag_inval_way;
        logic                  lru_touch;
        logic                  lru_way;
        logic                  hit;
        logic                  hit_way;
        logic                  victim_way;
        logic                  victim_dirty;
        logic [1:0]            way_dirty;
        logic                  data_way;
        logic                  data_word;
        logic                  data_wen;
        logic [`DC_WORD_W-1:0] data_wdata;
        logic [`DC_WORD_W-1:0] data_rdata;

        dcache_ctrl u_ctrl (
                .CLK            (CLK),
                .nRST           (nRST),
                .dmemREN        (dmemREN),
                .dmemWEN        (dmemWEN),
                .dmemaddr       (dmemaddr),
                .dmemstore      (dmemstore),
                .halt           (halt),
                .dhit           (dhit),
                .dmemload       (dmemload),
                .flushed        (flushed),
                .dload          (dload),
                .dwait          (dwait),
                .dREN           (dREN),
                .dWEN           (dWEN),
                .daddr          (daddr),
                .dstore         (dstore),
                .set_idx        (set_idx),
                .look_tag       (look_tag),
                .tag_fill       (tag_fill),
                .tag_fill_way   (tag_fill_way),
                .tag_fill_dirty (tag_fill_dirty),
                .tag_inval      (tag_inval),
                .tag_inval_way  (tag_inval_way),
                .lru_touch      (lru_touch),
                .lru_way        (lru_way),
                .hit            (hit),
                .hit_way        (hit_way),
                .victim_way     (victim_way),
                .victim_dirty   (victim_dirty),
                .victim_tag     (victim_tag),
                .way_dirty      (way_dirty),
                .data_way       (data_way),
                .data_word      (data_word),
                .data_wen       (data_wen),
                .data_wdata     (data_wdata),
                .data_rdata     (data_rdata)
        );

        dcache_tags u_tags (
                .CLK            (CLK),
                .nRST           (nRST),
                .set_idx        (set_idx),
                .look_tag       (look_tag),
                .tag_fill       (tag_fill),
                .tag_fill_way   (tag_fill_way),
                .tag_fill_dirty (tag_fill_dirty),
                .tag_inval      (tag_inval),
                .tag_inval_way  (tag_inval_way),
                .lru_touch      (lru_touch),
                .lru_way        (lru_way),
                .hit            (hit),
                .hit_way        (hit_way),
                .victim_way     (victim_way),
                .victim_dirty   (victim_dirty),
                .victim_tag     (victim_tag),
                .way_dirty      (way_dirty)
        );

        dcache_data u_data (
                .CLK        (CLK),
                .set_idx    (set_idx),
                .data_way   (data_way),
                .data_word  (data_word),
                .data_wen   (data_wen),
                .data_wdata (data_wdata),
                .data_rdata (data_rdata)
        );

endmodule

/* tb/mem_model.sv */
module mem_model (
        input  logic              CLK,
        input  logic              nRST,
        input  logic              dREN,
        input  logic              dWEN,
        input  dcache_pkg::word_t daddr,
        input  dcache_pkg::word_t dstore,
        output dcache_pkg::word_t dload,
        output logic              dwait,
        input  dcache_pkg::word_t peek_addr,
        output dcache_pkg::word_t peek_data
);
        import dcache_pkg::*;

        // only written words are kept, the rest follow the fill rule
        word_t  mem [word_t];
        integer seed = 32'hd675_2c52;
        logic   stall = 1'b0;
        word_t  rdata = '0;
        word_t  pdata = '0;

        function automatic word_t read_word(input word_t a);
                if (mem.exists(a)) begin
                        return mem[a];
                end
                return a ^ 32'h5a5a_0000;
        endfunction

        assign dwait     = stall;
        assign dload     = rdata;
        assign peek_data = pdata;

        // stall roughly one cycle in four
        always @(negedge CLK) begin
                stall <= (($random(seed) & 3) == 0);
                if (dREN) begin
                        rdata <= read_word(daddr);
                end
        end

        // debug read first, then the bus write
        always @(posedge CLK) begin
                pdata <= read_word(peek_addr);
                if (nRST && dWEN && !dwait) begin
                        mem[daddr] = dstore;
                end
        end

endmodule

/* tb/tb_dcache.sv */
module tb_dcache;
        import dcache_pkg::*;

        localparam int N_SET2         = 12;
        localparam int N_LRU          = 5;
        localparam int N_RAND         = 48;
        localparam int N_OPS          = N_SET2 + N_LRU + N_RAND + 1;
        localparam int TIMEOUT_CYCLES = 40 * N_OPS + 200;

        logic   CLK = 1'b0;
        logic   nRST = 1'b0;
        logic   dmemREN;
        logic   dmemWEN;
        word_t  dmemaddr;
        word_t  dmemstore;
        logic   halt;
        logic   dhit;
        word_t  dmemload;
        logic   flushed;
        logic   dREN;
        logic   dWEN;
        word_t  daddr;
        word_t  dstore;
        word_t  dload;
        logic   dwait;
        word_t  peek_addr;
        word_t  peek_data;

        integer seed;
        word_t  golden [word_t];
        tag_t   tag_pool [4];
        int     cycles = 0;
        int     err_load = 0;
        int     err_wb = 0;
        int     err_bus = 0;
        int     err_lru = 0;
        int     err_mem = 0;
        logic   hit_seen;
        logic   first_cyc = 1'b0;
        logic   expect_hit = 1'b0;
        logic   peek_on = 1'b0;
        logic   peek_chk = 1'b0;
        word_t  peek_addr_q = '0;
        logic   hold_q = 1'b0;
        word_t  daddr_q = '0;

        dcache u_dut (
                .CLK       (CLK),
                .nRST      (nRST),
                .dmemREN   (dmemREN),
                .dmemWEN   (dmemWEN),
                .dmemaddr  (dmemaddr),
                .dmemstore (dmemstore),
                .halt      (halt),
                .dload     (dload),
                .dwait     (dwait),
                .dhit      (dhit),
                .dmemload  (dmemload),
                .flushed   (flushed),
                .dREN      (dREN),
                .dWEN      (dWEN),
                .daddr     (daddr),
                .dstore    (dstore)
        );

        mem_model u_mem (
                .CLK       (CLK),
                .nRST      (nRST),
                .dREN      (dREN),
                .dWEN      (dWEN),
                .daddr     (daddr),
                .dstore    (dstore),
                .dload     (dload),
                .dwait     (dwait),
                .peek_addr (peek_addr),
                .peek_data (peek_data)
        );

        always #2 CLK = ~CLK;

        // memory starts as address xor 5a5a_0000
        function automatic word_t golden_word(input word_t a);
                if (golden.exists(a)) begin
                        return golden[a];
                end
                return a ^ 32'h5a5a_0000;
        endfunction

        function automatic word_t make_addr(input tag_t t, input idx_t i, input logic w);
                return {t, i, w, 2'b00};
        endfunction

        function automatic int error_total();
                return err_load + err_wb + err_bus + err_lru + err_mem;
        endfunction

        task automatic print_error_counts();
                $display("errors: load %0d, write-back %0d, bus %0d, lru %0d, memory %0d, total %0d",
                         err_load, err_wb, err_bus, err_lru, err_mem, error_total());
        endtask

        // one processor request, held until dhit
        task automatic access(input logic wr, input word_t addr, input word_t data);
                dmemREN   = ~wr;
                dmemWEN   = wr;
                dmemaddr  = addr;
                dmemstore = data;
                first_cyc = 1'b1;
                @(negedge CLK);
                first_cyc = 1'b0;
                while (!hit_seen) begin
                        @(negedge CLK);
                end
                if (wr) begin
                        golden[addr] = data;
                end
                dmemREN = 1'b0;
                dmemWEN = 1'b0;
        endtask

        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        hit_seen <= 1'b0;
                end else begin
                        hit_seen <= dhit;
                end
        end

        always @(posedge CLK) begin
                hold_q      <= (dREN || dWEN) && dwait;
                daddr_q     <= daddr;
                peek_chk    <= peek_on;
                peek_addr_q <= peek_addr;
        end

        always @(posedge CLK) begin
                cycles = cycles + 1;
                if (cycles > TIMEOUT_CYCLES) begin
                        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        print_error_counts();
                        $display("Test FAILED");
                        $finish;
                end
        end

        a_load: assert property (@(posedge CLK) disable iff (!nRST)
                (dhit && dmemREN) |-> (dmemload == golden_word(dmemaddr)))
        else begin
                err_load = err_load + 1;
                $display("[ERROR] %0t load %h returned %h, expected %h",
                         $time, dmemaddr, dmemload, golden_word(dmemaddr));
        end

        a_writeback: assert property (@(posedge CLK) disable iff (!nRST)
                (dWEN && !dwait) |-> (dstore == golden_word(daddr)))
        else begin
                err_wb = err_wb + 1;
                $display("[ERROR] %0t write-back to %h carries %h, expected %h",
                         $time, daddr, dstore, golden_word(daddr));
        end

        a_lru_hit: assert property (@(posedge CLK) disable iff (!nRST)
                (expect_hit && first_cyc) |-> dhit)
        else begin
                err_lru = err_lru + 1;
                $display("[ERROR] %0t read of %h missed after the lru sequence", $time, dmemaddr);
        end

        a_mem_final: assert property (@(posedge CLK) disable iff (!nRST)
                peek_chk |-> (peek_data == golden_word(peek_addr_q)))
        else begin
                err_mem = err_mem + 1;
                $display("[ERROR] %0t memory at %h holds %h, expected %h",
                         $time, peek_addr_q, peek_data, golden_word(peek_addr_q));
        end

        a_reset_idle: assert property (@(posedge CLK)
                !nRST |-> (!dREN && !dWEN && !dhit && !flushed))
        else begin
                err_bus = err_bus + 1;
                $display("[ERROR] %0t outputs active during reset", $time);
        end

        a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
                !(dREN && dWEN))
        else begin
                err_bus = err_bus + 1;
                $display("[ERROR] %0t dREN and dWEN high together", $time);
        end

        a_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
                hold_q |-> (daddr == daddr_q))
        else begin
                err_bus = err_bus + 1;
                $display("[ERROR] %0t daddr moved from %h to %h under dwait",
                         $time, daddr_q, daddr);
        end

        initial begin
                word_t pick;
                word_t a;
                tag_t  tg;

                dmemREN   = 1'b0;
                dmemWEN   = 1'b0;
                dmemaddr  = '0;
                dmemstore = '0;
                halt      = 1'b0;
                peek_addr = '0;
                seed      = 32'hd675_2c52;

                tag_pool[0] = 26'h000_0001;
                tag_pool[1] = 26'h000_2a4c;
                tag_pool[2] = 26'h155_5555;
                tag_pool[3] = 26'h3f0_0f0f;

                repeat (16) @(negedge CLK);
                nRST = 1'b1;
                @(negedge CLK);

                // three tags share set 2, so the third store evicts a dirty block
                for (int r = 0; r < 2; r++) begin
                        for (int k = 0; k < 3; k++) begin
                                access(1'b1, make_addr(tag_pool[k], 3'd2, r[0]), $random(seed));
                        end
                end
                for (int k = 0; k < 3; k++) begin
                        access(1'b0, make_addr(tag_pool[k], 3'd2, 1'b0), '0);
                        access(1'b0, make_addr(tag_pool[k], 3'd2, 1'b1), '0);
                end

                // A, B, A, then miss on C in set 5
                access(1'b1, make_addr(tag_pool[0], 3'd5, 1'b0), $random(seed));
                access(1'b0, make_addr(tag_pool[1], 3'd5, 1'b1), '0);
                access(1'b0, make_addr(tag_pool[0], 3'd5, 1'b1), '0);
                access(1'b1, make_addr(tag_pool[3], 3'd5, 1'b0), $random(seed));
                expect_hit = 1'b1;
                access(1'b0, make_addr(tag_pool[0], 3'd5, 1'b0), '0);
                expect_hit = 1'b0;

                for (int n = 0; n < N_RAND; n++) begin
                        pick = $random(seed);
                        tg   = tag_pool[pick[1:0]];
                        a    = make_addr(tg, pick[4:2], pick[6]);
                        access(pick[5], a, $random(seed));
                end

                halt = 1'b1;
                while (!flushed) begin
                        @(negedge CLK);
                end

                // every stored word must now sit in memory
                if (golden.first(a)) begin
                        do begin
                                peek_addr = a;
                                peek_on   = 1'b1;
                                @(negedge CLK);
                        end while (golden.next(a));
                end
                peek_on = 1'b0;
                repeat (2) @(negedge CLK);

                print_error_counts();
                if (error_total() == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

endmodule

/* flist.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_tags.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/dcache.sv
tb/mem_model.sv
tb/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f flist.f \
        && ./obj_dir/Vtb_dcache | tee /dev/stderr | grep "Test OK" > /dev/null \
        && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }
